// File: dv/apple2_host_glue_assertions.sv
// Concurrent checks on HDD request levels, CPU wait and the status writeback pulse
module apple2_host_glue_assertions (
	input logic clk_sys,
	input logic dd_reset,
	input logic sd_rd_hdd,
	input logic sd_wr_hdd,
	input logic cpu_wait,
	input logic status_set
);

	// ==================================================
	// HDD sequencer
	// ==================================================
	// Request levels only ever appear inside a CPU wait
	req_needs_wait: assert property (
		@(posedge clk_sys) disable iff (dd_reset) (sd_rd_hdd || sd_wr_hdd) |-> cpu_wait
	) else $error("HDD request level high while cpu_wait is low");

	wait_low_after_reset: assert property (
		@(posedge clk_sys) dd_reset |=> !cpu_wait
	) else $error("cpu_wait not low in the cycle after reset");

	// ==================================================
	// Display writeback
	// ==================================================
	set_single_cycle: assert property (
		@(posedge clk_sys) disable iff (dd_reset) status_set |=> !status_set
	) else $error("status_set high for two cycles in a row");

endmodule

// File: dv/apple2_host_glue_tb.sv
// Testbench with clock, reset, case file reader, LFSR ack timing and compare tasks
module apple2_host_glue_tb
	import apple2_glue_pkg::*;
();

	localparam int NUM_FLOPPY = 2;
	localparam int DRV_DLY    = 2;
	localparam int WAIT_LIMIT = 40;

	logic                  clk_sys, dd_reset;
	host_status_t          status, status_in;
	joy_digital_t          joystick_0;
	joy_analog_t           joystick_a0;
	paddle_t               paddle_0;
	machine_cfg_t          cfg;
	joy_out_t              joy;
	logic [1:0]            vga_sl;
	logic [NUM_FLOPPY:0]   img_mounted;
	disk_size_t            img_size;
	logic                  img_readonly, hdd_mounted, hdd_protect;
	logic [NUM_FLOPPY-1:0] disk_mount, disk_change;
	logic                  hdd_read, hdd_write, sd_ack_hdd, sd_rd_hdd, sd_wr_hdd, cpu_wait;
	logic                  video_toggle, palette_toggle, status_set;
	logic [31:0]           lfsr_state;
	int                    fd, num_cases, lat;
	string                 line, tag;
	logic [63:0]           f0, f1, f2, f3, f4, f5, f6;

	apple2_host_glue #(.NUM_FLOPPY(NUM_FLOPPY)) dut_i (.*);

	bind hdd_request_ctrl apple2_host_glue_assertions hdd_sva_i (.clk_sys, .dd_reset,
		.sd_rd_hdd, .sd_wr_hdd, .cpu_wait, .status_set(1'b0));
	bind display_mode_cycle apple2_host_glue_assertions disp_sva_i (.clk_sys, .dd_reset,
		.sd_rd_hdd(1'b0), .sd_wr_hdd(1'b0), .cpu_wait(1'b0), .status_set);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Helpers and compare tasks
	// ==================================================
	task automatic tick();
		@(posedge clk_sys);
		#DRV_DLY;
	endtask

	task automatic abort_run();
		$display("test failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic report_mismatch(input string msg);
		$display("Mismatch at time %0t: %s", $time, msg);
		abort_run();
	endtask

	task automatic check_cfg(input machine_cfg_t got, input machine_cfg_t exp);
		if (got !== exp)
			report_mismatch($sformatf("cfg is %h, expected %h", got, exp));
	endtask

	task automatic check_vga_sl(input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
			report_mismatch($sformatf("vga_sl is %0d, expected %0d", got, exp));
	endtask

	task automatic check_joy(input joy_out_t got, input joy_out_t exp);
		if (got !== exp)
			report_mismatch($sformatf("joy is %h, expected %h", got, exp));
	endtask

	task automatic check_mount(input logic [NUM_FLOPPY-1:0] mnt, input logic [NUM_FLOPPY-1:0] chg,
			input logic hdd_m, input logic hdd_p);
		if ({disk_mount, disk_change, hdd_mounted, hdd_protect} !== {mnt, chg, hdd_m, hdd_p})
			report_mismatch($sformatf("mount %b change %b hdd %b%b, expected %b %b %b%b",
				disk_mount, disk_change, hdd_mounted, hdd_protect, mnt, chg, hdd_m, hdd_p));
	endtask

	task automatic check_hdd_levels(input logic rd, input logic wr, input logic cw);
		if ({sd_rd_hdd, sd_wr_hdd, cpu_wait} !== {rd, wr, cw})
			report_mismatch($sformatf("rd/wr/wait are %b%b%b, expected %b%b%b",
				sd_rd_hdd, sd_wr_hdd, cpu_wait, rd, wr, cw));
	endtask

	task automatic check_status_in(input host_status_t got, input host_status_t exp);
		if (got !== exp)
			report_mismatch($sformatf("status_in is %h, expected %h", got, exp));
	endtask

	task automatic check_status_set(input logic exp);
		if (status_set !== exp)
			report_mismatch($sformatf("status_set is %b, expected %b", status_set, exp));
	endtask

	task automatic check_latency(input string what, input int got, input int exp);
		if (got != exp)
			report_mismatch($sformatf("%s after %0d cycles, expected %0d", what, got, exp));
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Ack phase length of 1 to 8 cycles, one LFSR step per bit
	task automatic random_hold(output int cycles);
		int v;
		v = 0;
		for (int i = 0; i < 3; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = (v << 1) | int'(lfsr_state[0]);
		end
		cycles = v + 1;
	endtask

	task automatic wait_cpu_wait(input logic level, output int cycles);
		cycles = 0;
		while (cpu_wait !== level) begin
			if (cycles >= WAIT_LIMIT) begin
				$display("Timeout: cpu_wait never went to %b", level);
				abort_run();
			end
			tick();
			cycles++;
		end
	endtask

	task automatic wait_status_set(output int cycles);
		cycles = 0;
		while (status_set !== 1'b1) begin
			if (cycles >= WAIT_LIMIT) begin
				$display("Timeout: no status_set pulse after a toggle change");
				abort_run();
			end
			tick();
			cycles++;
		end
	endtask

	// Pulse a request, then play the host ack sequence
	task automatic run_hdd(input logic rd, input logic wr, input logic exp_rd, input logic exp_wr);
		int n;
		hdd_read  = rd;
		hdd_write = wr;
		tick();
		hdd_read  = 1'b0;
		hdd_write = 1'b0;
		check_hdd_levels(1'b0, 1'b0, 1'b0);
		if (!(exp_rd | exp_wr)) begin
			repeat (3) begin
				tick();
				check_hdd_levels(1'b0, 1'b0, 1'b0);
			end
		end else begin
			wait_cpu_wait(1'b1, n);
			check_latency("Request level", n + 1, 2);
			check_hdd_levels(exp_rd, exp_wr, 1'b1);
			random_hold(n);
			repeat (n) begin
				tick();
				check_hdd_levels(exp_rd, exp_wr, 1'b1);
			end
			sd_ack_hdd = 1'b1;
			tick();
			check_hdd_levels(1'b0, 1'b0, 1'b1);
			random_hold(n);
			repeat (n - 1) begin
				tick();
				check_hdd_levels(1'b0, 1'b0, 1'b1);
			end
			sd_ack_hdd = 1'b0;
			wait_cpu_wait(1'b0, n);
			check_latency("CPU release", n, 1);
			check_hdd_levels(1'b0, 1'b0, 1'b0);
		end
	endtask

	// ==================================================
	// Case file sequence
	// ==================================================
	initial begin
		dd_reset       = 1'b1;
		status         = '0;
		joystick_0     = '0;
		joystick_a0    = '0;
		paddle_0       = '0;
		img_mounted    = '0;
		img_size       = '0;
		img_readonly   = 1'b0;
		hdd_read       = 1'b0;
		hdd_write      = 1'b0;
		sd_ack_hdd     = 1'b0;
		video_toggle   = 1'b0;
		palette_toggle = 1'b0;
		lfsr_state     = 32'ha550;
		num_cases      = 0;
		repeat (5) @(posedge clk_sys);
		#DRV_DLY;
		dd_reset = 1'b0;
		check_hdd_levels(1'b0, 1'b0, 1'b0);
		check_status_set(1'b0);

		fd = $fopen("dv/glue_cases.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the case file dv/glue_cases.txt");
			abort_run();
		end
		while ($fgets(line, fd) > 0) begin
			if ($sscanf(line, "%s", tag) != 1 || tag.getc(0) == "#")
				continue;
			void'($sscanf(line, "%s %h %h %h %h %h %h %h", tag, f0, f1, f2, f3, f4, f5, f6));
			num_cases++;
			if (tag == "STATUS") begin
				status = f0[31:0];
				tick();
				check_cfg(cfg, f1[13:0]);
				check_vga_sl(vga_sl, f2[1:0]);
			end else if (tag == "JOY") begin
				status      = f0[31:0];
				joystick_0  = f1[5:0];
				joystick_a0 = f2[15:0];
				paddle_0    = f3[7:0];
				tick();
				check_joy(joy, f4[21:0]);
			end else if (tag == "MOUNT") begin
				img_mounted  = f0[NUM_FLOPPY:0];
				img_size     = f1;
				img_readonly = f2[0];
				tick();
				img_mounted = '0;
				check_mount(f3[NUM_FLOPPY-1:0], f4[NUM_FLOPPY-1:0], f5[0], f6[0]);
			end else if (tag == "HDD") begin
				run_hdd(f0[0], f1[0], f2[0], f3[0]);
			end else if (tag == "TOGGLE") begin
				status         = f0[31:0];
				video_toggle   = video_toggle ^ f1[0];
				palette_toggle = palette_toggle ^ f2[0];
				wait_status_set(lat);
				check_latency("status_set pulse", lat, 1);
				check_status_in(status_in, f3[31:0]);
				tick();
				check_status_set(1'b0);
			end else begin
				$display("Unknown case kind %s in the case file", tag);
				abort_run();
			end
		end
		$fclose(fd);

		if (num_cases == 0) begin
			$display("No cases were read from the case file");
			abort_run();
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

// File: dv/glue_cases.txt
# STATUS status cfg vga_sl | JOY status buttons analog paddle joy | HDD rd wr exp_rd exp_wr
# MOUNT mask size readonly mount change hdd_mounted hdd_protect | TOGGLE status vflip pflip word
STATUS 00000000 2c00 0
STATUS 00000220 0c01 0
STATUS 0cd80990 331e 3
STATUS 03280c00 2dc0 1
STATUS 01200e20 0c60 2
JOY 00000000 3f 0000 00 3f0000
JOY 00000000 3f 1200 00 330012
JOY 00000040 3f 1200 00 3c1200
JOY 00020000 15 0080 40 14c000
JOY 00040040 2a 00ff 90 220010
MOUNT 1 23000 0 1 1 0 0
MOUNT 2 23000 1 3 3 0 0
MOUNT 1 0 0 2 2 0 0
MOUNT 4 2000000 1 2 2 1 1
MOUNT 4 2000000 0 2 2 1 0
MOUNT 2 23000 0 2 0 1 0
HDD 1 0 1 0
HDD 0 1 0 1
HDD 1 1 1 1
MOUNT 4 0 0 2 0 0 0
HDD 1 0 0 0
HDD 0 1 0 0
MOUNT 4 1000 1 2 0 1 1
HDD 0 1 0 1
TOGGLE 00000000 1 0 00080000
TOGGLE 00180000 1 0 00000000
TOGGLE 01100000 0 1 02000000
TOGGLE 83080a5f 1 1 80000a5f

// File: hdl/apple2_glue_pkg.sv
// Status bit positions, width typedefs, config and joystick structs, HDD request state enum
package apple2_glue_pkg;

	// ==================================================
	// Width types
	// ==================================================
	typedef logic [31:0] host_status_t;
	typedef logic [63:0] disk_size_t;
	// Display mode: 0 colour, 1 black and white, 2 green, 3 amber
	typedef logic [1:0]  screen_mode_t;
	typedef logic [1:0]  palette_t;
	typedef logic [15:0] joy_analog_t;
	typedef logic [5:0]  joy_digital_t;
	typedef logic [7:0]  paddle_t;

	localparam screen_mode_t SCREEN_COLOR = 2'd0;

	// ==================================================
	// Host status word bit map
	// ==================================================
	localparam int ST_COLD_RESET  = 0;
	// Option bits below are active low on the host side
	localparam int ST_MB_DISABLE  = 4;
	localparam int ST_CPU_SEL     = 5;
	localparam int ST_ANALOG_SWAP = 6;
	localparam int ST_STEREO_LO   = 7;
	localparam int ST_STEREO_HI   = 8;
	// Scandoubler effect field, 0 none, 1 HQ2x, 2..4 scanline levels
	localparam int ST_FX_LO       = 9;
	localparam int ST_FX_HI       = 11;
	localparam int ST_PADDLE_X    = 17;
	localparam int ST_PADDLE_Y    = 18;
	localparam int ST_DISPLAY_LO  = 19;
	localparam int ST_DISPLAY_HI  = 20;
	localparam int ST_TEXT_ART    = 21;
	localparam int ST_PAL_MODE    = 22;
	localparam int ST_ROM_SEL     = 23;
	localparam int ST_PALETTE_LO  = 24;
	localparam int ST_PALETTE_HI  = 25;
	localparam int ST_D1_WP       = 26;
	localparam int ST_D2_WP       = 27;

	// ==================================================
	// Structs and state
	// ==================================================
	typedef struct packed {
		logic         cpu_65c02;
		logic         pal_mode;
		logic         rom_us;
		logic         mb_enabled;
		screen_mode_t screen_mode;
		palette_t     palette;
		logic         text_color;
		logic         d1_wp;
		logic         d2_wp;
		logic [1:0]   stereo_mix;
		logic         hq2x;
	} machine_cfg_t;

	typedef struct packed {
		joy_digital_t digital;
		joy_analog_t  analog;
	} joy_out_t;

	typedef enum logic {
		HDD_IDLE,
		HDD_BUSY
	} hdd_state_e;

endpackage

// File: hdl/apple2_host_glue.sv
// Host glue top level with status decode, mount tracking, HDD sequencer and display writeback
module apple2_host_glue
	import apple2_glue_pkg::*;
#(
	parameter int NUM_FLOPPY = 2
)
(
	input  logic                  clk_sys,
	input  logic                  dd_reset,
	// Host status and controllers
	input  host_status_t          status,
	input  joy_digital_t          joystick_0,
	input  joy_analog_t           joystick_a0,
	input  paddle_t               paddle_0,
	output machine_cfg_t          cfg,
	output joy_out_t              joy,
	output logic [1:0]            vga_sl,
	// Image mounts
	input  logic [NUM_FLOPPY:0]   img_mounted,
	input  disk_size_t            img_size,
	input  logic                  img_readonly,
	output logic [NUM_FLOPPY-1:0] disk_mount,
	output logic [NUM_FLOPPY-1:0] disk_change,
	output logic                  hdd_mounted,
	output logic                  hdd_protect,
	// Hard disk requests
	input  logic                  hdd_read,
	input  logic                  hdd_write,
	input  logic                  sd_ack_hdd,
	output logic                  sd_rd_hdd,
	output logic                  sd_wr_hdd,
	output logic                  cpu_wait,
	// Display writeback
	input  logic                  video_toggle,
	input  logic                  palette_toggle,
	output logic                  status_set,
	output host_status_t          status_in
);

	// ==================================================
	// Decode
	// ==================================================
	host_status_decode decode_i (
		.clk_sys     (clk_sys),
		.dd_reset    (dd_reset),
		.status      (status),
		.joystick_0  (joystick_0),
		.joystick_a0 (joystick_a0),
		.paddle_0    (paddle_0),
		.cfg         (cfg),
		.joy         (joy),
		.vga_sl      (vga_sl)
	);

	// ==================================================
	// Execute
	// ==================================================
	image_mount_track #(
		.NUM_FLOPPY (NUM_FLOPPY)
	) mount_i (
		.clk_sys      (clk_sys),
		.dd_reset     (dd_reset),
		.img_mounted  (img_mounted),
		.img_size     (img_size),
		.img_readonly (img_readonly),
		.disk_mount   (disk_mount),
		.disk_change  (disk_change),
		.hdd_mounted  (hdd_mounted),
		.hdd_protect  (hdd_protect)
	);

	// Mount flag gates the request pulses
	hdd_request_ctrl hdd_i (
		.clk_sys     (clk_sys),
		.dd_reset    (dd_reset),
		.hdd_read    (hdd_read),
		.hdd_write   (hdd_write),
		.hdd_mounted (hdd_mounted),
		.sd_ack_hdd  (sd_ack_hdd),
		.sd_rd_hdd   (sd_rd_hdd),
		.sd_wr_hdd   (sd_wr_hdd),
		.cpu_wait    (cpu_wait)
	);

	// ==================================================
	// Result
	// ==================================================
	display_mode_cycle display_i (
		.clk_sys        (clk_sys),
		.dd_reset       (dd_reset),
		.status         (status),
		.video_toggle   (video_toggle),
		.palette_toggle (palette_toggle),
		.status_set     (status_set),
		.status_in      (status_in)
	);

endmodule

// File: hdl/display_mode_cycle.sv
// Keyboard toggle edge detect and status writeback for display mode and palette
module display_mode_cycle
	import apple2_glue_pkg::*;
(
	input  logic         clk_sys,
	input  logic         dd_reset,
	input  host_status_t status,
	input  logic         video_toggle,
	input  logic         palette_toggle,
	output logic         status_set,
	output host_status_t status_in
);

	logic         video_q;
	logic         palette_q;
	logic         video_chg;
	logic         palette_chg;
	screen_mode_t mode_next;
	palette_t     pal_next;
	host_status_t word_next;

	assign video_chg   = video_toggle != video_q;
	assign palette_chg = palette_toggle != palette_q;

	always_comb begin
		mode_next = status[ST_DISPLAY_HI:ST_DISPLAY_LO];
		pal_next  = status[ST_PALETTE_HI:ST_PALETTE_LO];
		if (video_chg) begin
			mode_next = status[ST_DISPLAY_HI:ST_DISPLAY_LO] + 2'd1;
		end
		// New palette is only visible in colour, so it overrides the mode step
		if (palette_chg) begin
			pal_next  = status[ST_PALETTE_HI:ST_PALETTE_LO] + 2'd1;
			mode_next = SCREEN_COLOR;
		end
		word_next = status;
		word_next[ST_DISPLAY_HI:ST_DISPLAY_LO] = mode_next;
		word_next[ST_PALETTE_HI:ST_PALETTE_LO] = pal_next;
	end

	always_ff @(posedge clk_sys) begin
		status_in <= word_next;
		if (dd_reset) begin
			video_q    <= 1'b0;
			palette_q  <= 1'b0;
			status_set <= 1'b0;
		end else begin
			video_q    <= video_toggle;
			palette_q  <= palette_toggle;
			status_set <= video_chg | palette_chg;
		end
	end

endmodule

// File: hdl/hdd_request_ctrl.sv
// Hard disk sector request sequencer with CPU wait
module hdd_request_ctrl
	import apple2_glue_pkg::*;
(
	input  logic clk_sys,
	input  logic dd_reset,
	input  logic hdd_read,
	input  logic hdd_write,
	input  logic hdd_mounted,
	input  logic sd_ack_hdd,
	output logic sd_rd_hdd,
	output logic sd_wr_hdd,
	output logic cpu_wait
);

	hdd_state_e state;
	logic       ack_q;
	logic       ack_rise;
	logic       ack_fall;
	logic       rd_req;
	logic       wr_req;
	logic       rd_pend;
	logic       wr_pend;

	// Requests with no image behind them go nowhere
	assign rd_req = hdd_read & hdd_mounted;
	assign wr_req = hdd_write & hdd_mounted;

	assign ack_rise = ~ack_q & sd_ack_hdd;
	assign ack_fall = ack_q & ~sd_ack_hdd;

	// ==================================================
	// Request sequencer
	// ==================================================
	// Host raises ack while it serves the sector and drops it when done.
	// Rise retires the request, fall lets the CPU run again.
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			state     <= HDD_IDLE;
			ack_q     <= 1'b0;
			rd_pend   <= 1'b0;
			wr_pend   <= 1'b0;
			sd_rd_hdd <= 1'b0;
			sd_wr_hdd <= 1'b0;
			cpu_wait  <= 1'b0;
		end else begin
			ack_q   <= sd_ack_hdd;
			rd_pend <= rd_pend | rd_req;
			wr_pend <= wr_pend | wr_req;

			case (state)
				HDD_IDLE: begin
					if (rd_pend | wr_pend) begin
						state     <= HDD_BUSY;
						// Both levels may go up together
						sd_rd_hdd <= rd_pend;
						sd_wr_hdd <= wr_pend;
						cpu_wait  <= 1'b1;
					end
				end
				HDD_BUSY: begin
					if (ack_rise) begin
						rd_pend   <= 1'b0;
						wr_pend   <= 1'b0;
						sd_rd_hdd <= 1'b0;
						sd_wr_hdd <= 1'b0;
					end else if (ack_fall) begin
						state    <= HDD_IDLE;
						cpu_wait <= 1'b0;
					end
				end
				default: begin
					state <= HDD_IDLE;
				end
			endcase
		end
	end

endmodule

// File: hdl/host_status_decode.sv
// Status word decode into machine settings, scanline level and joystick mapping
module host_status_decode
	import apple2_glue_pkg::*;
(
	input  logic         clk_sys,
	input  logic         dd_reset,
	input  host_status_t status,
	input  joy_digital_t joystick_0,
	input  joy_analog_t  joystick_a0,
	input  paddle_t      paddle_0,
	output machine_cfg_t cfg,
	output joy_out_t     joy,
	output logic [1:0]   vga_sl
);

	logic [2:0]   fx;
	logic [2:0]   sl_full;
	screen_mode_t mode;
	machine_cfg_t cfg_next;
	paddle_t      pdl;
	joy_analog_t  joys;
	joy_out_t     joy_next;

	assign fx   = status[ST_FX_HI:ST_FX_LO];
	assign mode = status[ST_DISPLAY_HI:ST_DISPLAY_LO];

	// Scanline level is the effect field minus one, floored at zero
	assign sl_full = (fx != 3'd0) ? fx - 3'd1 : 3'd0;

	// ==================================================
	// Machine settings
	// ==================================================
	always_comb begin
		cfg_next.cpu_65c02   = ~status[ST_CPU_SEL];
		cfg_next.pal_mode    = status[ST_PAL_MODE];
		cfg_next.rom_us      = ~status[ST_ROM_SEL];
		cfg_next.mb_enabled  = ~status[ST_MB_DISABLE];
		cfg_next.screen_mode = mode;
		cfg_next.palette     = status[ST_PALETTE_HI:ST_PALETTE_LO];
		// Lo-res artifacting only makes sense in colour mode
		cfg_next.text_color  = (mode == SCREEN_COLOR) && status[ST_TEXT_ART];
		cfg_next.d1_wp       = status[ST_D1_WP];
		cfg_next.d2_wp       = status[ST_D2_WP];
		cfg_next.stereo_mix  = status[ST_STEREO_HI:ST_STEREO_LO];
		cfg_next.hq2x        = (fx == 3'd1);
	end

	// ==================================================
	// Joystick and paddle mapping
	// ==================================================
	assign pdl  = {~paddle_0[7], paddle_0[6:0]};
	// Host delivers Y in the high byte, so swap by default
	assign joys = status[ST_ANALOG_SWAP] ? joystick_a0 : {joystick_a0[7:0], joystick_a0[15:8]};

	always_comb begin
		joy_next.analog[15:8] = status[ST_PADDLE_X] ? pdl : joys[15:8];
		joy_next.analog[7:0]  = status[ST_PADDLE_Y] ? pdl : joys[7:0];
		// Direction buttons are dropped while the stick is deflected on that axis
		joy_next.digital = joystick_0 & {2'b11, {2{~|joys[7:0]}}, {2{~|joys[15:8]}}};
	end

	// Decoded outputs follow the status word one cycle later
	always_ff @(posedge clk_sys) begin
		cfg <= cfg_next;
		joy <= joy_next;
		if (dd_reset) begin
			vga_sl <= 2'd0;
		end else begin
			vga_sl <= sl_full[1:0];
		end
	end

endmodule

// File: hdl/image_mount_track.sv
// Floppy mount and change flags, hard disk mount and protect flags
module image_mount_track
	import apple2_glue_pkg::*;
#(
	parameter int NUM_FLOPPY = 2
)
(
	input  logic                  clk_sys,
	input  logic                  dd_reset,
	input  logic [NUM_FLOPPY:0]   img_mounted,
	input  disk_size_t            img_size,
	input  logic                  img_readonly,
	output logic [NUM_FLOPPY-1:0] disk_mount,
	output logic [NUM_FLOPPY-1:0] disk_change,
	output logic                  hdd_mounted,
	output logic                  hdd_protect
);

	// Hard disk sits above the floppy units in the mount vector
	localparam int HDD_UNIT = NUM_FLOPPY;

	logic size_nonzero;

	assign size_nonzero = (img_size != '0);

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			disk_mount  <= '0;
			disk_change <= '0;
			hdd_mounted <= 1'b0;
			hdd_protect <= 1'b0;
		end else begin
			for (int i = 0; i < NUM_FLOPPY; i++) begin
				if (img_mounted[i]) begin
					disk_mount[i]  <= size_nonzero;
					// Floppy controller watches this bit for any edge
					disk_change[i] <= ~disk_change[i];
				end
			end
			if (img_mounted[HDD_UNIT]) begin
				hdd_mounted <= size_nonzero;
				hdd_protect <= img_readonly;
			end
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the host glue testbench with Verilator, run it and scan the log
LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module apple2_host_glue_tb \
	-Mdir obj_dir -o sim_glue
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_glue > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "test failed" "$LOG"; then
	exit 1
fi
exit 0

// File: vlog.f
hdl/apple2_glue_pkg.sv
hdl/host_status_decode.sv
hdl/image_mount_track.sv
hdl/hdd_request_ctrl.sv
hdl/display_mode_cycle.sv
hdl/apple2_host_glue.sv
dv/apple2_host_glue_assertions.sv
dv/apple2_host_glue_tb.sv
